// File: bcd_converter.sv
// conv_magnitude must stay stable from conv_start until conv_done
`default_nettype none

module bcd_converter
    import cal_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       conv_start,
    input  magnitude_t conv_magnitude,
    output logic       conv_done,
    output bcd6_t      conv_digits
);
    logic                 busy;
    logic [STEP_BITS-1:0] step;

    function automatic bcd6_t add3(bcd6_t v);
        bcd6_t r;
        r = v;
        for (int i = 0; i < 6; i++) begin
            if (r[4*i +: 4] >= 4'd5) r[4*i +: 4] = r[4*i +: 4] + 4'd3;
        end
        return r;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            step      <= '0;
            conv_done <= 1'b0;
        end else begin
            conv_done <= 1'b0;
            if (conv_start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == STEP_BITS'(MAG_BITS - 1)) begin
                    busy      <= 1'b0;
                    conv_done <= 1'b1;
                end
            end
        end
    end

    // msb first, one bit per cycle
    always_ff @(posedge clk) begin
        if (conv_start) begin
            conv_digits <= '0;
        end else if (busy) begin
            conv_digits <= bcd6_t'({add3(conv_digits),
                                    conv_magnitude[STEP_BITS'(MAG_BITS - 1) - step]});
        end
    end

endmodule

`default_nettype wire

// File: button_conditioner.sv
// raw buttons are assumed active high; a press reaches btn DEBOUNCE_CYCLES+2 cycles after the edge
`default_nettype none

module button_conditioner
    import cal_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [BUTTON_WIDTH-1:0] buttons,
    button_if.source                btn
);
    logic [BUTTON_WIDTH-1:0]  raw_q;
    logic [BUTTON_WIDTH-1:0]  level;
    logic [BUTTON_WIDTH-1:0]  level_q;
    logic [BUTTON_WIDTH-1:0]  rise;
    logic [BUTTON_WIDTH-1:0]  press;
    logic [DEBOUNCE_BITS-1:0] cnt [BUTTON_WIDTH];

    assign rise = level & ~level_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            raw_q   <= '0;
            level   <= '0;
            level_q <= '0;
            press   <= '0;
            for (int i = 0; i < BUTTON_WIDTH; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            raw_q   <= buttons;
            level_q <= level;
            // lowest index wins when presses collide
            press   <= rise & (~rise + 1'b1);
            for (int i = 0; i < BUTTON_WIDTH; i++) begin
                if (raw_q[i] == level[i]) begin
                    cnt[i] <= '0;
                end else if (cnt[i] == DEBOUNCE_BITS'(DEBOUNCE_CYCLES - 1)) begin
                    level[i] <= raw_q[i];
                    cnt[i]   <= '0;
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign btn.left  = press[BTN_LEFT];
    assign btn.right = press[BTN_RIGHT];
    assign btn.up    = press[BTN_UP];
    assign btn.down  = press[BTN_DOWN];
    assign btn.mid   = press[BTN_MID];

    // one clock wide per press, however long the button is held
    a_press_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        (press & $past(press)) == '0);

endmodule

`default_nettype wire

// File: button_if.sv
// qualified press pulses, each one clock wide, at most one per cycle
`default_nettype none

interface button_if;
    logic left;
    logic right;
    logic up;
    logic down;
    logic mid;

    modport source (
        output left, right, up, down, mid
    );

    modport sink (
        input left, right, up, down, mid
    );
endinterface

`default_nettype wire

// File: cal_control.sv
// switches are sampled with operand B; only add, sub and mul are valid, the lowest set switch wins
`default_nettype none

module cal_control
    import cal_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    button_if.sink                  btn,
    digit_bus_if.sink               digits,
    input  logic [SWITCH_WIDTH-1:0] switches,
    input  logic                    last_page,
    input  logic                    conv_done,
    output logic                    entry_clear,
    output logic                    entry_active,
    output logic                    conv_start,
    output magnitude_t              conv_magnitude,
    output logic                    result_negative,
    output logic                    result_invalid,
    output logic                    show_input,
    output logic                    show_result,
    output logic                    exe_done
);
    ctrl_state_t             state;
    ctrl_state_t             state_d;
    operand_t                entered_mag;
    operand_t                entered;
    operand_t                op_a;
    operand_t                op_b;
    logic [SWITCH_WIDTH-1:0] sw_q;
    logic [SWITCH_WIDTH-1:0] op_sel;
    result_t                 a_ext;
    result_t                 b_ext;
    result_t                 result;

    always_comb begin
        state_d = state;
        unique case (state)
            CTRL_IDLE:    state_d = CTRL_INPUT_A;
            CTRL_INPUT_A: if (btn.mid) state_d = CTRL_INPUT_B;
            CTRL_INPUT_B: if (btn.mid) state_d = CTRL_EXE;
            CTRL_EXE:     state_d = CTRL_CONVERT;
            CTRL_CONVERT: if (conv_done) state_d = CTRL_DISPLAY;
            CTRL_DISPLAY: if (btn.mid && last_page) state_d = CTRL_INPUT_A;
            default:      state_d = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= CTRL_IDLE;
        end else begin
            state <= state_d;
        end
    end

    // decimal entry to two's complement
    assign entered_mag = operand_t'(digits.digit2) * 11'sd100
                       + operand_t'(digits.digit1) * 11'sd10
                       + operand_t'(digits.digit0);
    assign entered     = digits.sign ? -entered_mag : entered_mag;

    assign op_sel         = sw_q & (~sw_q + 1'b1);
    assign result_invalid = !(op_sel[OP_ADD] || op_sel[OP_SUB] || op_sel[OP_MUL]);

    assign a_ext = result_t'(op_a);
    assign b_ext = result_t'(op_b);

    always_comb begin
        if (op_sel[OP_MUL]) begin
            result = a_ext * b_ext;
        end else if (op_sel[OP_SUB]) begin
            result = a_ext - b_ext;
        end else begin
            result = a_ext + b_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (state == CTRL_INPUT_A && btn.mid) begin
            op_a <= entered;
        end
        if (state == CTRL_INPUT_B && btn.mid) begin
            op_b <= entered;
            sw_q <= switches;
        end
        if (state == CTRL_EXE) begin
            result_negative <= result[20];
            conv_magnitude  <= magnitude_t'(result[20] ? -result : result);
        end
    end

    assign entry_clear  = (state_d != state)
                        && (state_d inside {CTRL_INPUT_A, CTRL_INPUT_B, CTRL_EXE});
    assign entry_active = state inside {CTRL_INPUT_A, CTRL_INPUT_B};
    assign show_input   = entry_active;
    assign conv_start   = state == CTRL_EXE;
    assign show_result  = state == CTRL_DISPLAY;
    assign exe_done     = show_result;

    a_ctrl_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(state));

endmodule

`default_nettype wire

// File: cal_pkg.sv
// DEBOUNCE_CYCLES and SCAN_CYCLES are sized for simulation, scale them up for a real board
`default_nettype none

package cal_pkg;

    typedef logic [3:0] digit_t;
    typedef logic signed [10:0] operand_t;
    typedef logic signed [20:0] result_t;
    typedef logic [19:0] magnitude_t;
    typedef logic [23:0] bcd6_t;
    typedef logic [7:0] seg_t;

    localparam digit_t BLANK_CODE = 4'd10;
    localparam digit_t MINUS_CODE = 4'd11;

    typedef enum logic [5:0] {
        CTRL_IDLE    = 6'b000001,
        CTRL_INPUT_A = 6'b000010,
        CTRL_INPUT_B = 6'b000100,
        CTRL_EXE     = 6'b001000,
        CTRL_CONVERT = 6'b010000,
        CTRL_DISPLAY = 6'b100000
    } ctrl_state_t;

    typedef enum logic [4:0] {
        ENTRY_IDLE   = 5'b00001,
        ENTRY_DIGIT0 = 5'b00010,
        ENTRY_DIGIT1 = 5'b00100,
        ENTRY_DIGIT2 = 5'b01000,
        ENTRY_SIGN   = 5'b10000
    } entry_state_t;

    localparam int BUTTON_WIDTH = 5;
    localparam int BTN_LEFT     = 0;
    localparam int BTN_RIGHT    = 1;
    localparam int BTN_UP       = 2;
    localparam int BTN_DOWN     = 3;
    localparam int BTN_MID      = 4;

    localparam int SWITCH_WIDTH = 15;
    localparam int OP_ADD       = 0;
    localparam int OP_SUB       = 1;
    localparam int OP_MUL       = 2;

    localparam int DEBOUNCE_CYCLES = 8;
    localparam int DEBOUNCE_BITS   = $clog2(DEBOUNCE_CYCLES);
    localparam int SCAN_CYCLES     = 4;
    localparam int SCAN_BITS       = $clog2(SCAN_CYCLES);
    localparam int MAG_BITS        = 20;
    localparam int STEP_BITS       = $clog2(MAG_BITS);

    // active low, segment a in the msb, dp in the lsb
    function automatic seg_t seg_pattern(digit_t code);
        case (code)
            4'd0:       return 8'b0000_0011;
            4'd1:       return 8'b1001_1111;
            4'd2:       return 8'b0010_0101;
            4'd3:       return 8'b0000_1101;
            4'd4:       return 8'b1001_1001;
            4'd5:       return 8'b0100_1001;
            4'd6:       return 8'b0100_0001;
            4'd7:       return 8'b0001_1111;
            4'd8:       return 8'b0000_0001;
            4'd9:       return 8'b0001_1001;
            MINUS_CODE: return 8'b1111_1101;
            default:    return 8'b1111_1111;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: cal_top.sv
// single clock domain; board buttons need no synchronizer beyond the conditioner's input register
`default_nettype none

module cal_top
    import cal_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [BUTTON_WIDTH-1:0] board_cal_button,
    input  logic [SWITCH_WIDTH-1:0] board_cal_switchs,
    output logic [3:0]              cal_board_digit_ctrl,
    output seg_t                    cal_board_digit_seg,
    output logic                    cal_board_exe_done,
    output logic [2:0]              cal_board_display_stage
);
    logic       entry_clear;
    logic       entry_active;
    logic       conv_start;
    logic       conv_done;
    magnitude_t conv_magnitude;
    bcd6_t      conv_digits;
    logic       result_negative;
    logic       result_invalid;
    logic       show_input;
    logic       show_result;
    logic       last_page;

    button_if    btn ();
    digit_bus_if digits ();

    button_conditioner u_button_conditioner (
        .clk     (clk),
        .arst_n  (arst_n),
        .buttons (board_cal_button),
        .btn     (btn)
    );

    operand_entry u_operand_entry (
        .clk          (clk),
        .arst_n       (arst_n),
        .btn          (btn),
        .entry_clear  (entry_clear),
        .entry_active (entry_active),
        .digits       (digits)
    );

    cal_control u_cal_control (
        .clk             (clk),
        .arst_n          (arst_n),
        .btn             (btn),
        .digits          (digits),
        .switches        (board_cal_switchs),
        .last_page       (last_page),
        .conv_done       (conv_done),
        .entry_clear     (entry_clear),
        .entry_active    (entry_active),
        .conv_start      (conv_start),
        .conv_magnitude  (conv_magnitude),
        .result_negative (result_negative),
        .result_invalid  (result_invalid),
        .show_input      (show_input),
        .show_result     (show_result),
        .exe_done        (cal_board_exe_done)
    );

    bcd_converter u_bcd_converter (
        .clk            (clk),
        .arst_n         (arst_n),
        .conv_start     (conv_start),
        .conv_magnitude (conv_magnitude),
        .conv_done      (conv_done),
        .conv_digits    (conv_digits)
    );

    display_scan u_display_scan (
        .clk             (clk),
        .arst_n          (arst_n),
        .btn             (btn),
        .digits          (digits),
        .show_input      (show_input),
        .show_result     (show_result),
        .result_negative (result_negative),
        .result_invalid  (result_invalid),
        .conv_digits     (conv_digits),
        .last_page       (last_page),
        .digit_ctrl      (cal_board_digit_ctrl),
        .digit_seg       (cal_board_digit_seg),
        .display_stage   (cal_board_display_stage)
    );

endmodule

`default_nettype wire

// File: digit_bus_if.sv
// digit0 is the ones digit, digit2 the hundreds; sign set means negative
`default_nettype none

interface digit_bus_if import cal_pkg::*; ();
    digit_t digit0;
    digit_t digit1;
    digit_t digit2;
    logic   sign;

    modport source (
        output digit0, digit1, digit2, sign
    );

    modport sink (
        input digit0, digit1, digit2, sign
    );
endinterface

`default_nettype wire

// File: display_scan.sv
// digit_ctrl and digit_seg are active low; position 0 is the rightmost digit
`default_nettype none

module display_scan
    import cal_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    button_if.sink     btn,
    digit_bus_if.sink  digits,
    input  logic       show_input,
    input  logic       show_result,
    input  logic       result_negative,
    input  logic       result_invalid,
    input  bcd6_t      conv_digits,
    output logic       last_page,
    output logic [3:0] digit_ctrl,
    output seg_t       digit_seg,
    output logic [2:0] display_stage
);
    logic [SCAN_BITS-1:0] scan_cnt;
    logic [1:0]           pos;
    logic                 page;
    logic                 two_page;
    digit_t               sign_code;
    digit_t               code;
    logic [15:0]          page_word;

    // scan strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_cnt <= '0;
            pos      <= '0;
        end else if (scan_cnt == SCAN_BITS'(SCAN_CYCLES - 1)) begin
            scan_cnt <= '0;
            pos      <= pos + 2'd1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // magnitude of 1000 or more needs a second page
    assign two_page  = |conv_digits[23:12];
    assign last_page = result_invalid || !two_page || page;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            page <= 1'b0;
        end else if (!show_result) begin
            page <= 1'b0;
        end else if (btn.mid && !last_page) begin
            page <= 1'b1;
        end
    end

    assign display_stage = {2'b00, page} + 3'd1;

    always_comb begin
        sign_code = BLANK_CODE;
        if (show_input) begin
            if (digits.sign) sign_code = MINUS_CODE;
            page_word = {sign_code, digits.digit2, digits.digit1, digits.digit0};
        end else begin
            // sign only on the first page
            if (result_negative && !page) sign_code = MINUS_CODE;
            page_word = {sign_code, (two_page && !page) ? conv_digits[23:12] : conv_digits[11:0]};
        end
    end

    assign code       = page_word[{pos, 2'b00} +: 4];
    assign digit_seg  = seg_pattern(code);
    assign digit_ctrl = (show_input || (show_result && !result_invalid))
                      ? ~(4'b0001 << pos) : 4'b1111;

endmodule

`default_nettype wire

// File: operand_entry.sv
// presses outside an active entry are dropped; entry_clear overrides any press in the same cycle
`default_nettype none

module operand_entry
    import cal_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    button_if.sink       btn,
    input  logic         entry_clear,
    input  logic         entry_active,
    digit_bus_if.source  digits
);
    entry_state_t state;
    entry_state_t state_d;

    function automatic digit_t step_digit(digit_t d, logic up);
        if (up) begin
            return (d == 4'd9) ? 4'd0 : d + 4'd1;
        end
        return (d == 4'd0) ? 4'd9 : d - 4'd1;
    endfunction

    // left walks toward the sign position, right walks back
    always_comb begin
        state_d = state;
        unique case (state)
            ENTRY_IDLE: begin
                if (entry_active) state_d = ENTRY_DIGIT0;
            end
            ENTRY_DIGIT0: begin
                if (btn.left) state_d = ENTRY_DIGIT1;
            end
            ENTRY_DIGIT1: begin
                if (btn.left) state_d = ENTRY_DIGIT2;
                else if (btn.right) state_d = ENTRY_DIGIT0;
            end
            ENTRY_DIGIT2: begin
                if (btn.left) state_d = ENTRY_SIGN;
                else if (btn.right) state_d = ENTRY_DIGIT1;
            end
            ENTRY_SIGN: begin
                if (btn.right) state_d = ENTRY_DIGIT2;
            end
            default: state_d = ENTRY_IDLE;
        endcase
        if (entry_clear) state_d = ENTRY_IDLE;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ENTRY_IDLE;
        end else begin
            state <= state_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            digits.digit0 <= '0;
            digits.digit1 <= '0;
            digits.digit2 <= '0;
            digits.sign   <= 1'b0;
        end else if (entry_clear) begin
            digits.digit0 <= '0;
            digits.digit1 <= '0;
            digits.digit2 <= '0;
            digits.sign   <= 1'b0;
        end else if (btn.up || btn.down) begin
            if (state == ENTRY_DIGIT0) digits.digit0 <= step_digit(digits.digit0, btn.up);
            if (state == ENTRY_DIGIT1) digits.digit1 <= step_digit(digits.digit1, btn.up);
            if (state == ENTRY_DIGIT2) digits.digit2 <= step_digit(digits.digit2, btn.up);
            if (state == ENTRY_SIGN) digits.sign <= ~digits.sign;
        end
    end

    a_entry_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(state));

endmodule

`default_nettype wire

// File: project.f
+incdir+.
cal_pkg.sv
button_if.sv
digit_bus_if.sv
button_conditioner.sv
operand_entry.sv
cal_control.sv
bcd_converter.sv
display_scan.sv
cal_top.sv
tb_cal_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cal_top -f project.f \
    && ./obj_dir/Vtb_cal_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_cal_checks.svh
// included inside the testbench module; uses its digit_ctrl, digit_seg, test_name and counters
`ifndef TB_CAL_CHECKS_SVH
`define TB_CAL_CHECKS_SVH

// active low patterns for 0 to 9, blank, minus
seg_t seg_table [12] = '{
    8'h03, 8'h9f, 8'h25, 8'h0d, 8'h99, 8'h49,
    8'h41, 8'h1f, 8'h01, 8'h19, 8'hff, 8'hfd
};

seg_t page_segs [4];

// unknown pattern decodes to 15
function automatic digit_t decode_seg(seg_t s);
    for (int i = 0; i < 12; i++) begin
        if (seg_table[4'(i)] == s) return digit_t'(i);
    end
    return 4'hf;
endfunction

// one pass over the four scan positions
task automatic capture_page();
    int         waited;
    logic [3:0] want;
    for (int p = 0; p < 4; p++) begin
        want   = ~(4'b0001 << p);
        waited = 0;
        @(negedge clk);
        while (digit_ctrl !== want && waited < 8 * SCAN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (digit_ctrl !== want) begin
            timeout_count++;
            $display("timeout in %s: digit enable for position %0d never came", test_name, p);
            return;
        end
        page_segs[2'(p)] = digit_seg;
    end
endtask

task automatic check_digit(input string what, input digit_t expected, input digit_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("FAIL %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
    end
endtask

task automatic check_seg(input string what, input seg_t expected, input seg_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("FAIL %s: %s expected %02h, actual %02h", test_name, what, expected, actual);
    end
endtask

task automatic check_stage(input string what, input logic [2:0] expected,
                           input logic [2:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("FAIL %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
    end
endtask

task automatic check_ctrl(input string what, input logic [3:0] expected,
                          input logic [3:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("FAIL %s: %s expected %b, actual %b", test_name, what, expected, actual);
    end
endtask

task automatic check_flag(input string what, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("FAIL %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
    end
endtask

// display order, sign position first
task automatic check_page(input digit_t d3, input digit_t d2, input digit_t d1, input digit_t d0);
    capture_page();
    check_digit("pos0", d0, decode_seg(page_segs[0]));
    check_digit("pos1", d1, decode_seg(page_segs[1]));
    check_digit("pos2", d2, decode_seg(page_segs[2]));
    check_seg("pos3", seg_table[d3], page_segs[3]);
endtask

`endif

// File: tb_cal_top.sv
// directed tests only; runtime assumes the small simulation values of DEBOUNCE_CYCLES and SCAN_CYCLES
`default_nettype none

module tb_cal_top import cal_pkg::*; ();
    logic                    clk = 1'b0;
    logic                    arst_n = 1'b0;
    logic [BUTTON_WIDTH-1:0] buttons = '0;
    logic [SWITCH_WIDTH-1:0] switches = '0;
    logic [3:0]              digit_ctrl;
    seg_t                    digit_seg;
    logic                    exe_done;
    logic [2:0]              display_stage;

    string       test_name = "init";
    int          check_count = 0;
    int          error_count = 0;
    int          timeout_count = 0;
    int unsigned lcg_state = 99;

    `include "tb_cal_checks.svh"

    always #5 clk = ~clk;

    cal_top uut (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .board_cal_button        (buttons),
        .board_cal_switchs       (switches),
        .cal_board_digit_ctrl    (digit_ctrl),
        .cal_board_digit_seg     (digit_seg),
        .cal_board_exe_done      (exe_done),
        .cal_board_display_stage (display_stage)
    );

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic int rand_operand();
        int mag;
        mag = int'(lcg_next() % 32'd999) + 1;
        if ((lcg_next() & 32'd1) != 0) mag = -mag;
        return mag;
    endfunction

    function automatic logic [BUTTON_WIDTH-1:0] button_mask(input int idx);
        return BUTTON_WIDTH'(1) << idx;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        arst_n   <= 1'b0;
        buttons  <= '0;
        switches <= '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    // held long enough to debounce, then released for as long
    task automatic press(input logic [BUTTON_WIDTH-1:0] mask);
        @(posedge clk);
        buttons <= mask;
        repeat (DEBOUNCE_CYCLES + 4) @(posedge clk);
        buttons <= '0;
        repeat (DEBOUNCE_CYCLES + 4) @(posedge clk);
    endtask

    task automatic wait_exe_done(input logic level);
        int waited;
        waited = 0;
        @(negedge clk);
        while (exe_done !== level && waited < 10 * MAG_BITS) begin
            @(negedge clk);
            waited++;
        end
        if (exe_done !== level) begin
            timeout_count++;
            $display("timeout in %s: exe_done never went to %0d", test_name, level);
        end
    endtask

    // starts on digit0 with cleared digits, ends on the sign position
    task automatic enter_operand(input int value);
        int mag;
        int d;
        mag = (value < 0) ? -value : value;
        for (int p = 0; p < 3; p++) begin
            d   = mag % 10;
            mag = mag / 10;
            if (d <= 5) repeat (d) press(button_mask(BTN_UP));
            else repeat (10 - d) press(button_mask(BTN_DOWN));
            press(button_mask(BTN_LEFT));
        end
        if (value < 0) press(button_mask(BTN_UP));
    endtask

    task automatic calculate(input int a, input int b, input logic [SWITCH_WIDTH-1:0] sw);
        enter_operand(a);
        press(button_mask(BTN_MID));
        enter_operand(b);
        @(posedge clk);
        switches <= sw;
        press(button_mask(BTN_MID));
        wait_exe_done(1'b1);
    endtask

    // pages of 1000 or more split at the thousands digit
    task automatic check_result(input int value, input int page);
        int     m;
        int     base;
        digit_t sign_code;
        m         = (value < 0) ? -value : value;
        base      = (m >= 1000 && page == 1) ? m / 1000 : m % 1000;
        sign_code = (page == 1 && value < 0) ? MINUS_CODE : BLANK_CODE;
        check_stage("display_stage", 3'(page), display_stage);
        check_page(sign_code, digit_t'(base / 100 % 10), digit_t'(base / 10 % 10),
                   digit_t'(base % 10));
    endtask

    task automatic check_after_reset();
        test_name = "reset";
        apply_reset();
        @(negedge clk);
        check_ctrl("digit_ctrl", 4'b1111, digit_ctrl);
        check_flag("exe_done", 1'b0, exe_done);
        check_stage("display_stage", 3'd1, display_stage);
        check_page(BLANK_CODE, 4'd0, 4'd0, 4'd0);
    endtask

    task automatic edit_digits();
        test_name = "entry";
        apply_reset();
        press(button_mask(BTN_DOWN));
        check_page(BLANK_CODE, 4'd0, 4'd0, 4'd9);
        repeat (2) press(button_mask(BTN_LEFT));
        repeat (3) press(button_mask(BTN_UP));
        press(button_mask(BTN_LEFT));
        press(button_mask(BTN_UP));
        check_page(MINUS_CODE, 4'd3, 4'd0, 4'd9);
        // back to digit2, then left and up together, left wins
        press(button_mask(BTN_RIGHT));
        press(button_mask(BTN_LEFT) | button_mask(BTN_UP));
        check_page(MINUS_CODE, 4'd3, 4'd0, 4'd9);
        press(button_mask(BTN_UP));
        check_page(BLANK_CODE, 4'd3, 4'd0, 4'd9);
    endtask

    task automatic one_page_case(input int a, input int b, input int op);
        int expected;
        expected = (op == OP_SUB) ? a - b : a + b;
        calculate(a, b, SWITCH_WIDTH'(1) << op);
        check_flag("exe_done", 1'b1, exe_done);
        check_result(expected, 1);
        press(button_mask(BTN_MID));
        wait_exe_done(1'b0);
    endtask

    task automatic add_and_subtract();
        test_name = "add_sub";
        apply_reset();
        one_page_case(-123, 45, OP_ADD);
        one_page_case(250, 317, OP_SUB);
        one_page_case(608, 391, OP_ADD);
    endtask

    task automatic multiply_two_pages();
        int a;
        int b;
        int product;
        int tries;
        test_name = "multiply";
        tries     = 0;
        apply_reset();
        do begin
            a       = rand_operand();
            b       = rand_operand();
            product = a * b;
            tries++;
        end while (((product < 0) ? -product : product) < 1000 && tries < 100);
        calculate(a, b, SWITCH_WIDTH'(1) << OP_MUL);
        check_result(product, 1);
        press(button_mask(BTN_MID));
        check_result(product, 2);
        press(button_mask(BTN_MID));
        wait_exe_done(1'b0);
        check_flag("exe_done", 1'b0, exe_done);
        check_page(BLANK_CODE, 4'd0, 4'd0, 4'd0);
    endtask

    // operands sum past 999, so only the invalid rule keeps it to one page
    task automatic invalid_case(input logic [SWITCH_WIDTH-1:0] sw);
        calculate(700, 800, sw);
        for (int p = 0; p < 4; p++) begin
            repeat (SCAN_CYCLES) @(negedge clk);
            check_ctrl("digit_ctrl", 4'b1111, digit_ctrl);
        end
        check_stage("display_stage", 3'd1, display_stage);
        press(button_mask(BTN_MID));
        wait_exe_done(1'b0);
        check_page(BLANK_CODE, 4'd0, 4'd0, 4'd0);
    endtask

    task automatic reject_invalid_op();
        test_name = "invalid";
        apply_reset();
        invalid_case(SWITCH_WIDTH'(1) << 5);
        invalid_case('0);
    endtask

    initial begin
        check_after_reset();
        edit_digits();
        add_and_subtract();
        multiply_two_pages();
        reject_invalid_op();
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
